// File: Bender.yml
package:
  name: decode_riscv

sources:
  - files:
      - rtl/riscv_decode_pkg.sv
      - rtl/fetch_capture.sv
      - rtl/op_decode.sv
      - rtl/imm_gen.sv
      - rtl/uop_register.sv
      - rtl/decode_riscv.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_decode_riscv.sv

// File: decode_riscv.f
+incdir+tb
rtl/riscv_decode_pkg.sv
rtl/fetch_capture.sv
rtl/op_decode.sv
rtl/imm_gen.sv
rtl/uop_register.sv
rtl/decode_riscv.sv
tb/tb_decode_riscv.sv

// File: rtl/decode_riscv.sv
module decode_riscv(
   clk,
   reset,
   insn_valid,
   insn,
   pc,
   page_fault,
   irq,
   uop_valid,
   uop);

   input logic clk;
   input logic reset;
   input logic insn_valid;
   input logic [31:0] insn;
   input logic [riscv_decode_pkg::xlen-1:0] pc;
   input logic page_fault;
   input logic irq;
   output logic uop_valid;
   output riscv_decode_pkg::uop_t uop;

   riscv_decode_pkg::fetch_t fetch;
   riscv_decode_pkg::uop_t dec_uop;
   riscv_decode_pkg::uop_t full_uop;
   riscv_decode_pkg::imm_fmt_t imm_fmt;
   logic [riscv_decode_pkg::xlen-1:0] rvimm;

   fetch_capture u_fetch(.clk(clk), .reset(reset), .insn_valid(insn_valid), .insn(insn),
                         .pc(pc), .page_fault(page_fault), .irq(irq), .fetch(fetch));

   op_decode u_decode(.fetch(fetch), .uop(dec_uop), .imm_fmt(imm_fmt));

   imm_gen u_imm(.insn(fetch.insn), .pc(fetch.pc), .imm_fmt(imm_fmt), .rvimm(rvimm));

   always_comb
   begin
      full_uop = dec_uop;
      full_uop.rvimm = rvimm; // decoder leaves rvimm zero
   end

   uop_register u_out(.clk(clk), .reset(reset), .valid(fetch.valid), .uop_in(full_uop),
                      .uop_valid(uop_valid), .uop(uop));

endmodule

// File: rtl/fetch_capture.sv
module fetch_capture(
   clk,
   reset,
   insn_valid,
   insn,
   pc,
   page_fault,
   irq,
   fetch);

   input logic clk;
   input logic reset;
   input logic insn_valid;
   input logic [31:0] insn;
   input logic [riscv_decode_pkg::xlen-1:0] pc;
   input logic page_fault;
   input logic irq;
   output riscv_decode_pkg::fetch_t fetch;

   logic valid_q;
   logic [31:0] insn_q;
   logic [riscv_decode_pkg::xlen-1:0] pc_q;
   logic page_fault_q;
   logic irq_q;

   always_ff @(posedge clk)
   begin
      if (reset)
         valid_q <= 1'b0;
      else
         valid_q <= insn_valid;
   end

   always_ff @(posedge clk)
   begin
      if (insn_valid) // hold last word when idle
      begin
         insn_q <= insn;
         pc_q <= pc;
         page_fault_q <= page_fault;
         irq_q <= irq;
      end
   end

   assign fetch = {valid_q, insn_q, pc_q, page_fault_q, irq_q};

endmodule

// File: rtl/imm_gen.sv
module imm_gen(
   insn,
   pc,
   imm_fmt,
   rvimm);

   input riscv_decode_pkg::insn_u insn;
   input logic [riscv_decode_pkg::xlen-1:0] pc;
   input riscv_decode_pkg::imm_fmt_t imm_fmt;
   output logic [riscv_decode_pkg::xlen-1:0] rvimm;

   localparam int pp = riscv_decode_pkg::xlen - 32;

   logic [riscv_decode_pkg::xlen-1:0] imm;
   logic add_pc;

   always_comb
   begin
      imm = '0;
      add_pc = 1'b0;
      case (imm_fmt)
         riscv_decode_pkg::IMM_I:
            imm = {{(pp+20){insn.i.imm_11_0[11]}}, insn.i.imm_11_0};
         riscv_decode_pkg::IMM_S:
            imm = {{(pp+20){insn.s.imm_11_5[6]}}, insn.s.imm_11_5, insn.s.imm_4_0};
         riscv_decode_pkg::IMM_U:
            imm = {{pp{insn.u.imm_31_12[19]}}, insn.u.imm_31_12, 12'd0};
         riscv_decode_pkg::IMM_U_PC:
         begin
            imm = {{pp{insn.u.imm_31_12[19]}}, insn.u.imm_31_12, 12'd0};
            add_pc = 1'b1; // auipc
         end
         riscv_decode_pkg::IMM_B_PC:
         begin
            imm = {{(pp+19){insn.b.imm_12}}, insn.b.imm_12, insn.b.imm_11,
                   insn.b.imm_10_5, insn.b.imm_4_1, 1'b0};
            add_pc = 1'b1; // branch target
         end
         riscv_decode_pkg::IMM_J_PC:
         begin
            imm = {{(pp+11){insn.j.imm_20}}, insn.j.imm_20, insn.j.imm_19_12,
                   insn.j.imm_11, insn.j.imm_10_1, 1'b0};
            add_pc = 1'b1; // jal target
         end
         default:
            imm = '0;
      endcase
   end

   assign rvimm = add_pc ? (pc + imm) : imm;

endmodule

// File: rtl/op_decode.sv
module op_decode(
   fetch,
   uop,
   imm_fmt);

   input riscv_decode_pkg::fetch_t fetch;
   output riscv_decode_pkg::uop_t uop;
   output riscv_decode_pkg::imm_fmt_t imm_fmt;

   localparam int zp = riscv_decode_pkg::prf_idx_width - 5;

   wire [riscv_decode_pkg::prf_idx_width-1:0] rd = {{zp{1'b0}}, fetch.insn.r.rd};
   wire [riscv_decode_pkg::prf_idx_width-1:0] rs1 = {{zp{1'b0}}, fetch.insn.r.rs1};
   wire [riscv_decode_pkg::prf_idx_width-1:0] rs2 = {{zp{1'b0}}, fetch.insn.r.rs2};
   wire [2:0] funct3 = fetch.insn.r.funct3;
   wire [6:0] funct7 = fetch.insn.r.funct7;
   wire [5:0] funct6 = fetch.insn.i.imm_11_0[11:6]; // rv64 shamt is 6 bits
   wire rs1_is_link = (rs1 == 'd1) || (rs1 == 'd5);

   logic is_alu;

   always_comb
   begin
      uop = '0;
      uop.pc = fetch.pc;
      imm_fmt = riscv_decode_pkg::IMM_NONE;
      is_alu = 1'b0;
      case (fetch.insn.r.opcode)
         riscv_decode_pkg::OPC_LOAD:
         begin
            uop.dst = rd;
            uop.src_a = rs1;
            uop.dst_valid = (rd != 'd0);
            uop.src_a_valid = 1'b1;
            uop.is_mem = 1'b1;
            imm_fmt = riscv_decode_pkg::IMM_I;
            case (funct3)
               3'd0: uop.op = riscv_decode_pkg::LB;
               3'd1: uop.op = riscv_decode_pkg::LH;
               3'd2: uop.op = riscv_decode_pkg::LW;
               3'd3: uop.op = riscv_decode_pkg::LD;
               3'd4: uop.op = riscv_decode_pkg::LBU;
               3'd5: uop.op = riscv_decode_pkg::LHU;
               3'd6: uop.op = riscv_decode_pkg::LWU;
               default: uop.op = riscv_decode_pkg::II;
            endcase
         end
         riscv_decode_pkg::OPC_MISC_MEM: uop.op = riscv_decode_pkg::NOP; // fence
         riscv_decode_pkg::OPC_OP_IMM:
         begin
            uop.dst = rd;
            uop.src_a = rs1;
            uop.dst_valid = (rd != 'd0);
            uop.src_a_valid = (rd != 'd0);
            uop.is_int = 1'b1;
            uop.is_cheap_int = 1'b1;
            imm_fmt = riscv_decode_pkg::IMM_I;
            is_alu = 1'b1;
            case (funct3)
               3'd0: uop.op = riscv_decode_pkg::ADDI;
               3'd1: uop.op = riscv_decode_pkg::SLLI;
               3'd2: uop.op = riscv_decode_pkg::SLTI;
               3'd3: uop.op = riscv_decode_pkg::SLTIU;
               3'd4: uop.op = riscv_decode_pkg::XORI;
               3'd5:
               begin
                  if (funct6 == 6'h00)
                     uop.op = riscv_decode_pkg::SRLI;
                  else if (funct6 == 6'h10)
                     uop.op = riscv_decode_pkg::SRAI;
               end
               3'd6: uop.op = riscv_decode_pkg::ORI;
               default: uop.op = riscv_decode_pkg::ANDI;
            endcase
         end
         riscv_decode_pkg::OPC_AUIPC, riscv_decode_pkg::OPC_LUI:
         begin
            uop.dst = rd;
            uop.dst_valid = (rd != 'd0);
            uop.is_int = 1'b1;
            uop.is_cheap_int = 1'b1;
            is_alu = 1'b1;
            if (fetch.insn.r.opcode == riscv_decode_pkg::OPC_LUI)
            begin
               uop.op = riscv_decode_pkg::LUI;
               imm_fmt = riscv_decode_pkg::IMM_U;
            end
            else
            begin
               uop.op = riscv_decode_pkg::AUIPC;
               imm_fmt = riscv_decode_pkg::IMM_U_PC;
            end
         end
         riscv_decode_pkg::OPC_STORE:
         begin
            uop.src_a = rs1;
            uop.src_b = rs2;
            uop.src_a_valid = 1'b1;
            uop.src_b_valid = 1'b1;
            uop.is_mem = 1'b1;
            uop.is_store = 1'b1;
            imm_fmt = riscv_decode_pkg::IMM_S;
            case (funct3)
               3'd0: uop.op = riscv_decode_pkg::SB;
               3'd1: uop.op = riscv_decode_pkg::SH;
               3'd2: uop.op = riscv_decode_pkg::SW;
               3'd3: uop.op = riscv_decode_pkg::SD;
               default: uop.op = riscv_decode_pkg::II;
            endcase
         end
         riscv_decode_pkg::OPC_OP:
         begin
            uop.dst = rd;
            uop.src_a = rs1;
            uop.src_b = rs2;
            uop.dst_valid = (rd != 'd0);
            uop.src_a_valid = 1'b1;
            uop.src_b_valid = 1'b1;
            uop.is_int = 1'b1;
            is_alu = 1'b1;
            case ({funct7, funct3})
               {7'h00, 3'd0}: uop.op = riscv_decode_pkg::ADDU;
               {7'h20, 3'd0}: uop.op = riscv_decode_pkg::SUBU;
               {7'h00, 3'd1}: uop.op = riscv_decode_pkg::SLL;
               {7'h00, 3'd2}: uop.op = riscv_decode_pkg::SLT;
               {7'h00, 3'd3}: uop.op = riscv_decode_pkg::SLTU;
               {7'h00, 3'd4}: uop.op = riscv_decode_pkg::XOR;
               {7'h00, 3'd5}: uop.op = riscv_decode_pkg::SRL;
               {7'h20, 3'd5}: uop.op = riscv_decode_pkg::SRA;
               {7'h00, 3'd6}: uop.op = riscv_decode_pkg::OR;
               {7'h00, 3'd7}: uop.op = riscv_decode_pkg::AND;
               {7'h01, 3'd0}: uop.op = riscv_decode_pkg::MUL;
               {7'h01, 3'd1}: uop.op = riscv_decode_pkg::MULH;
               {7'h01, 3'd3}: uop.op = riscv_decode_pkg::MULHU;
               {7'h01, 3'd4}: uop.op = riscv_decode_pkg::DIV;
               {7'h01, 3'd5}: uop.op = riscv_decode_pkg::DIVU;
               {7'h01, 3'd6}: uop.op = riscv_decode_pkg::REM;
               {7'h01, 3'd7}: uop.op = riscv_decode_pkg::REMU;
               default: uop.op = riscv_decode_pkg::II; // mulhsu not handled
            endcase
         end
         riscv_decode_pkg::OPC_BRANCH:
         begin
            uop.src_a = rs1;
            uop.src_b = rs2;
            uop.src_a_valid = 1'b1;
            uop.src_b_valid = 1'b1;
            uop.is_int = 1'b1;
            uop.is_br = 1'b1;
            imm_fmt = riscv_decode_pkg::IMM_B_PC;
            case (funct3)
               3'd0: uop.op = riscv_decode_pkg::BEQ;
               3'd1: uop.op = riscv_decode_pkg::BNE;
               3'd4: uop.op = riscv_decode_pkg::BLT;
               3'd5: uop.op = riscv_decode_pkg::BGE;
               3'd6: uop.op = riscv_decode_pkg::BLTU;
               3'd7: uop.op = riscv_decode_pkg::BGEU;
               default: uop.op = riscv_decode_pkg::II;
            endcase
         end
         riscv_decode_pkg::OPC_JALR:
         begin
            uop.src_a = rs1;
            uop.src_a_valid = 1'b1;
            uop.is_int = 1'b1;
            uop.is_cheap_int = 1'b1;
            uop.is_br = 1'b1;
            imm_fmt = riscv_decode_pkg::IMM_I;
            if (rd == 'd0)
               uop.op = rs1_is_link ? riscv_decode_pkg::RET : riscv_decode_pkg::JR;
            else
            begin
               uop.op = riscv_decode_pkg::JALR;
               uop.dst = rd;
               uop.dst_valid = 1'b1;
            end
         end
         riscv_decode_pkg::OPC_JAL:
         begin
            uop.is_int = 1'b1;
            uop.is_br = 1'b1;
            imm_fmt = riscv_decode_pkg::IMM_J_PC;
            if (rd == 'd0)
               uop.op = riscv_decode_pkg::J;
            else
            begin
               uop.op = riscv_decode_pkg::JAL;
               uop.dst = rd;
               uop.dst_valid = 1'b1;
               uop.is_cheap_int = 1'b1; // link write only
            end
         end
         default: uop.op = riscv_decode_pkg::II; // system and unknown opcodes
      endcase

      if (is_alu && (rd == 'd0) && (uop.op != riscv_decode_pkg::II))
         uop.op = riscv_decode_pkg::NOP; // result to x0 is dropped

      // faults and bad encodings keep only op and pc
      if (fetch.page_fault || fetch.irq || (uop.op == riscv_decode_pkg::II))
      begin
         uop = '0;
         uop.op = fetch.page_fault ? riscv_decode_pkg::FETCH_PF :
                  fetch.irq ? riscv_decode_pkg::IRQ : riscv_decode_pkg::II;
         uop.pc = fetch.pc;
         imm_fmt = riscv_decode_pkg::IMM_NONE;
      end
   end

endmodule

// File: rtl/riscv_decode_pkg.sv
package riscv_decode_pkg;

   localparam int xlen = 64;
   localparam int prf_idx_width = 6; // arch index zero-extended from 5 bits

   // major opcodes, prefixed to stay apart from the uop names
   typedef enum logic [6:0] {
      OPC_LOAD     = 7'h03,
      OPC_MISC_MEM = 7'h0f,
      OPC_OP_IMM   = 7'h13,
      OPC_AUIPC    = 7'h17,
      OPC_STORE    = 7'h23,
      OPC_OP       = 7'h33,
      OPC_LUI      = 7'h37,
      OPC_BRANCH   = 7'h63,
      OPC_JALR     = 7'h67,
      OPC_JAL      = 7'h6f,
      OPC_SYSTEM   = 7'h73
   } opcode_t;

   typedef enum logic [7:0] {
      II, NOP, FETCH_PF, IRQ,                               // II must stay zero
      LB, LH, LW, LD, LBU, LHU, LWU,
      SB, SH, SW, SD,
      ADDI, SLLI, SLTI, SLTIU, XORI, SRLI, SRAI, ORI, ANDI,
      ADDU, SUBU, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
      MUL, MULH, MULHU, DIV, DIVU, REM, REMU,
      LUI, AUIPC,
      BEQ, BNE, BLT, BGE, BLTU, BGEU,
      J, JAL, JR, JALR, RET
   } uop_op_t;

   typedef enum logic [2:0] {
      IMM_NONE, IMM_I, IMM_S, IMM_U, IMM_U_PC, IMM_B_PC, IMM_J_PC
   } imm_fmt_t;

   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      opcode_t    opcode;
   } r_fmt_t;

   typedef struct packed {
      logic [11:0] imm_11_0;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      opcode_t     opcode;
   } i_fmt_t;

   typedef struct packed {
      logic [6:0] imm_11_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_4_0;
      opcode_t    opcode;
   } s_fmt_t;

   typedef struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      opcode_t    opcode;
   } b_fmt_t;

   typedef struct packed {
      logic [19:0] imm_31_12;
      logic [4:0]  rd;
      opcode_t     opcode;
   } u_fmt_t;

   typedef struct packed {
      logic       imm_20;
      logic [9:0] imm_10_1;
      logic       imm_11;
      logic [7:0] imm_19_12;
      logic [4:0] rd;
      opcode_t    opcode;
   } j_fmt_t;

   typedef union packed {
      r_fmt_t r;
      i_fmt_t i;
      s_fmt_t s;
      b_fmt_t b;
      u_fmt_t u;
      j_fmt_t j;
   } insn_u;

   typedef struct packed {
      logic            valid;
      insn_u           insn;
      logic [xlen-1:0] pc;
      logic            page_fault;
      logic            irq;
   } fetch_t;

   typedef struct packed {
      uop_op_t                  op;
      logic [prf_idx_width-1:0] src_a;
      logic [prf_idx_width-1:0] src_b;
      logic [prf_idx_width-1:0] dst;
      logic                     src_a_valid;
      logic                     src_b_valid;
      logic                     dst_valid;
      logic [xlen-1:0]          rvimm;
      logic [xlen-1:0]          pc;
      logic                     is_mem;
      logic                     is_store;
      logic                     is_int;
      logic                     is_cheap_int;
      logic                     is_br;
   } uop_t;

endpackage

// File: rtl/uop_register.sv
module uop_register(
   clk,
   reset,
   valid,
   uop_in,
   uop_valid,
   uop);

   input logic clk;
   input logic reset;
   input logic valid;
   input riscv_decode_pkg::uop_t uop_in;
   output logic uop_valid;
   output riscv_decode_pkg::uop_t uop;

   always_ff @(posedge clk)
   begin
      if (reset)
         uop_valid <= 1'b0;
      else
         uop_valid <= valid;
   end

   always_ff @(posedge clk)
   begin
      if (valid)
         uop <= uop_in; // stale when valid drops
   end

endmodule

// File: tb/decode_vectors.svh
   task automatic load_vectors;
   begin
      // name, {page_fault, irq, insn}, op, dst, src_a, src_b,
      // {dst_v, src_a_v, src_b_v}_{mem, store, int, cheap, br}_{pc relative}, imm
      add_row("addi", 34'h0_ff808193, riscv_decode_pkg::ADDI, 3, 1, 0, 9'b110_00110_0, -8);
      add_row("slli", 34'h0_03f09193, riscv_decode_pkg::SLLI, 3, 1, 0, 9'b110_00110_0, 63);
      add_row("slti", 34'h0_0640a193, riscv_decode_pkg::SLTI, 3, 1, 0, 9'b110_00110_0, 100);
      add_row("sltiu", 34'h0_fff0b193, riscv_decode_pkg::SLTIU, 3, 1, 0, 9'b110_00110_0, -1);
      add_row("xori", 34'h0_5550c193, riscv_decode_pkg::XORI, 3, 1, 0, 9'b110_00110_0, 1365);
      add_row("srli", 34'h0_0050d193, riscv_decode_pkg::SRLI, 3, 1, 0, 9'b110_00110_0, 5);
      add_row("srai", 34'h0_4210d193, riscv_decode_pkg::SRAI, 3, 1, 0, 9'b110_00110_0, 1057);
      add_row("ori", 34'h0_7ff0e193, riscv_decode_pkg::ORI, 3, 1, 0, 9'b110_00110_0, 2047);
      add_row("andi", 34'h0_8000f193, riscv_decode_pkg::ANDI, 3, 1, 0, 9'b110_00110_0, -2048);
      add_row("addi_x0", 34'h0_00108013, riscv_decode_pkg::NOP, 0, 1, 0, 9'b000_00110_0, 1);
      add_row("add", 34'h0_002081b3, riscv_decode_pkg::ADDU, 3, 1, 2, 9'b111_00100_0, 0);
      add_row("sub", 34'h0_402081b3, riscv_decode_pkg::SUBU, 3, 1, 2, 9'b111_00100_0, 0);
      add_row("sll", 34'h0_002091b3, riscv_decode_pkg::SLL, 3, 1, 2, 9'b111_00100_0, 0);
      add_row("slt", 34'h0_0020a1b3, riscv_decode_pkg::SLT, 3, 1, 2, 9'b111_00100_0, 0);
      add_row("sltu", 34'h0_0020b1b3, riscv_decode_pkg::SLTU, 3, 1, 2, 9'b111_00100_0, 0);
      add_row("xor", 34'h0_0020c1b3, riscv_decode_pkg::XOR, 3, 1, 2, 9'b111_00100_0, 0);
      add_row("srl", 34'h0_0020d1b3, riscv_decode_pkg::SRL, 3, 1, 2, 9'b111_00100_0, 0);
      add_row("sra", 34'h0_4020d1b3, riscv_decode_pkg::SRA, 3, 1, 2, 9'b111_00100_0, 0);
      add_row("or", 34'h0_0020e1b3, riscv_decode_pkg::OR, 3, 1, 2, 9'b111_00100_0, 0);
      add_row("and", 34'h0_0020f1b3, riscv_decode_pkg::AND, 3, 1, 2, 9'b111_00100_0, 0);
      add_row("mul", 34'h0_022081b3, riscv_decode_pkg::MUL, 3, 1, 2, 9'b111_00100_0, 0);
      add_row("mulh", 34'h0_022091b3, riscv_decode_pkg::MULH, 3, 1, 2, 9'b111_00100_0, 0);
      add_row("mulhu", 34'h0_0220b1b3, riscv_decode_pkg::MULHU, 3, 1, 2, 9'b111_00100_0, 0);
      add_row("div", 34'h0_0220c1b3, riscv_decode_pkg::DIV, 3, 1, 2, 9'b111_00100_0, 0);
      add_row("divu", 34'h0_0220d1b3, riscv_decode_pkg::DIVU, 3, 1, 2, 9'b111_00100_0, 0);
      add_row("rem", 34'h0_0220e1b3, riscv_decode_pkg::REM, 3, 1, 2, 9'b111_00100_0, 0);
      add_row("remu", 34'h0_0220f1b3, riscv_decode_pkg::REMU, 3, 1, 2, 9'b111_00100_0, 0);
      add_row("add_x0", 34'h0_00208033, riscv_decode_pkg::NOP, 0, 1, 2, 9'b011_00100_0, 0);
      add_row("mulhsu", 34'h0_0220a1b3, riscv_decode_pkg::II, 0, 0, 0, 9'b000_00000_0, 0);
      add_row("lb", 34'h0_fff08183, riscv_decode_pkg::LB, 3, 1, 0, 9'b110_10000_0, -1);
      add_row("lh", 34'h0_00209183, riscv_decode_pkg::LH, 3, 1, 0, 9'b110_10000_0, 2);
      add_row("lw", 34'h0_ffc0a183, riscv_decode_pkg::LW, 3, 1, 0, 9'b110_10000_0, -4);
      add_row("ld", 34'h0_0080b183, riscv_decode_pkg::LD, 3, 1, 0, 9'b110_10000_0, 8);
      add_row("lbu", 34'h0_7ff0c183, riscv_decode_pkg::LBU, 3, 1, 0, 9'b110_10000_0, 2047);
      add_row("lhu", 34'h0_8000d183, riscv_decode_pkg::LHU, 3, 1, 0, 9'b110_10000_0, -2048);
      add_row("lwu", 34'h0_0100e183, riscv_decode_pkg::LWU, 3, 1, 0, 9'b110_10000_0, 16);
      add_row("ld_bad", 34'h0_0000f183, riscv_decode_pkg::II, 0, 0, 0, 9'b000_00000_0, 0);
      add_row("sb", 34'h0_fe208fa3, riscv_decode_pkg::SB, 0, 1, 2, 9'b011_11000_0, -1);
      add_row("sh", 34'h0_00209323, riscv_decode_pkg::SH, 0, 1, 2, 9'b011_11000_0, 6);
      add_row("sw", 34'h0_0220a423, riscv_decode_pkg::SW, 0, 1, 2, 9'b011_11000_0, 40);
      add_row("sd", 34'h0_fe20b823, riscv_decode_pkg::SD, 0, 1, 2, 9'b011_11000_0, -16);
      add_row("lui", 34'h0_123451b7, riscv_decode_pkg::LUI, 3, 0, 0, 9'b100_00110_0, 'h12345000);
      add_row("lui_neg", 34'h0_fffff1b7, riscv_decode_pkg::LUI, 3, 0, 0, 9'b100_00110_0, -4096);
      add_row("auipc", 34'h0_00010197, riscv_decode_pkg::AUIPC, 3, 0, 0, 9'b100_00110_1, 65536);
      add_row("auipc_n", 34'h0_fffff197, riscv_decode_pkg::AUIPC, 3, 0, 0, 9'b100_00110_1, -4096);
      add_row("beq", 34'h0_00208863, riscv_decode_pkg::BEQ, 0, 1, 2, 9'b011_00101_1, 16);
      add_row("bne", 34'h0_fe209ee3, riscv_decode_pkg::BNE, 0, 1, 2, 9'b011_00101_1, -4);
      add_row("blt", 34'h0_0020c0e3, riscv_decode_pkg::BLT, 0, 1, 2, 9'b011_00101_1, 2048);
      add_row("bge", 34'h0_8020d063, riscv_decode_pkg::BGE, 0, 1, 2, 9'b011_00101_1, -4096);
      add_row("bltu", 34'h0_7e20ef63, riscv_decode_pkg::BLTU, 0, 1, 2, 9'b011_00101_1, 2046);
      add_row("bgeu", 34'h0_0020f463, riscv_decode_pkg::BGEU, 0, 1, 2, 9'b011_00101_1, 8);
      add_row("br_bad", 34'h0_0020a063, riscv_decode_pkg::II, 0, 0, 0, 9'b000_00000_0, 0);
      add_row("jal", 34'h0_001000ef, riscv_decode_pkg::JAL, 1, 0, 0, 9'b100_00111_1, 2048);
      add_row("jal_x5", 34'h0_000012ef, riscv_decode_pkg::JAL, 5, 0, 0, 9'b100_00111_1, 4096);
      add_row("j", 34'h0_ff9ff06f, riscv_decode_pkg::J, 0, 0, 0, 9'b000_00101_1, -8);
      add_row("ret", 34'h0_00008067, riscv_decode_pkg::RET, 0, 1, 0, 9'b010_00111_0, 0);
      add_row("ret_x5", 34'h0_00028067, riscv_decode_pkg::RET, 0, 5, 0, 9'b010_00111_0, 0);
      add_row("jr", 34'h0_00c30067, riscv_decode_pkg::JR, 0, 6, 0, 9'b010_00111_0, 12);
      add_row("jalr", 34'h0_ffc080e7, riscv_decode_pkg::JALR, 1, 1, 0, 9'b110_00111_0, -4);
      add_row("pf", 34'h2_ff808193, riscv_decode_pkg::FETCH_PF, 0, 0, 0, 9'b000_00000_0, 0);
      add_row("pf_irq", 34'h3_0020c1b3, riscv_decode_pkg::FETCH_PF, 0, 0, 0, 9'b000_00000_0, 0);
      add_row("irq", 34'h1_ffc080e7, riscv_decode_pkg::IRQ, 0, 0, 0, 9'b000_00000_0, 0);
      add_row("fence", 34'h0_0ff0000f, riscv_decode_pkg::NOP, 0, 0, 0, 9'b000_00000_0, 0);
      add_row("ecall", 34'h0_00000073, riscv_decode_pkg::II, 0, 0, 0, 9'b000_00000_0, 0);
      add_row("csrrw", 34'h0_300091f3, riscv_decode_pkg::II, 0, 0, 0, 9'b000_00000_0, 0);
      add_row("zero", 34'h0_00000000, riscv_decode_pkg::II, 0, 0, 0, 9'b000_00000_0, 0);
      add_row("op_7f", 34'h0_0000007f, riscv_decode_pkg::II, 0, 0, 0, 9'b000_00000_0, 0);
      add_row("addiw", 34'h0_0010819b, riscv_decode_pkg::II, 0, 0, 0, 9'b000_00000_0, 0);
   end
   endtask

// File: tb/tb_decode_riscv.sv
module tb_decode_riscv;

   typedef struct packed {
      logic [33:0] stim;                                 // {page_fault, irq, insn}
      riscv_decode_pkg::uop_op_t op;
      logic [riscv_decode_pkg::prf_idx_width-1:0] dst;
      logic [riscv_decode_pkg::prf_idx_width-1:0] src_a;
      logic [riscv_decode_pkg::prf_idx_width-1:0] src_b;
      logic [8:0] bits;                                  // valids, class flags, pc relative
      logic [riscv_decode_pkg::xlen-1:0] imm;
   } vec_t;

   typedef struct packed {
      logic [31:0] idx;
      logic [31:0] due;                                  // negedge cycle of the result
      logic [riscv_decode_pkg::xlen-1:0] pc;
   } pend_t;

   logic clk;
   logic reset;
   logic insn_valid;
   logic [31:0] insn;
   logic [riscv_decode_pkg::xlen-1:0] pc;
   logic page_fault;
   logic irq;
   logic uop_valid;
   riscv_decode_pkg::uop_t uop;

   vec_t vectors[$];
   string names[$];
   pend_t pending[$];
   pend_t head;
   int cycle = 0;
   int limit = 0;
   int errors = 0;
   int passed = 0;
   int failed = 0;
   int seed = 32'hf3a0d296;

   decode_riscv uut(.clk(clk), .reset(reset), .insn_valid(insn_valid), .insn(insn), .pc(pc),
                    .page_fault(page_fault), .irq(irq), .uop_valid(uop_valid), .uop(uop));

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(posedge clk)
      cycle <= cycle + 1;

   task automatic add_row(input string name, input logic [33:0] stim,
                          input riscv_decode_pkg::uop_op_t op, input logic [5:0] dst,
                          input logic [5:0] src_a, input logic [5:0] src_b,
                          input logic [8:0] bits, input logic [63:0] imm);
      vec_t v;
      begin
         v.stim = stim;
         v.op = op;
         v.dst = dst;
         v.src_a = src_a;
         v.src_b = src_b;
         v.bits = bits;
         v.imm = imm;
         vectors.push_back(v);
         names.push_back(name);
      end
   endtask

`include "decode_vectors.svh"

   task automatic check_uop(input pend_t p);
      vec_t v;
      riscv_decode_pkg::uop_t expect_uop;
      bit ok;
      begin
         v = vectors[p.idx];
         ok = 1'b1;
         expect_uop = '0;
         expect_uop.op = v.op;
         expect_uop.src_a = v.src_a;
         expect_uop.src_b = v.src_b;
         expect_uop.dst = v.dst;
         {expect_uop.dst_valid, expect_uop.src_a_valid, expect_uop.src_b_valid} = v.bits[8:6];
         {expect_uop.is_mem, expect_uop.is_store, expect_uop.is_int, expect_uop.is_cheap_int,
          expect_uop.is_br} = v.bits[5:1];
         expect_uop.rvimm = v.bits[0] ? (p.pc + v.imm) : v.imm; // target = pc + offset
         expect_uop.pc = p.pc;
         assert (uop_valid === 1'b1)
         else
         begin
            $display("%s: uop_valid was low when the result was due", names[p.idx]);
            ok = 1'b0;
         end
         assert (uop === expect_uop)
         else
         begin
            $display("MISMATCH %s expected %h actual %h", names[p.idx], expect_uop, uop);
            ok = 1'b0;
         end
         if (ok)
            passed++;
         else
         begin
            failed++;
            errors++;
         end
         $display("test %0d %s: %s", p.idx, names[p.idx], ok ? "ok" : "failed");
      end
   endtask

   // outputs settle after the posedge, so look at them half a cycle later
   always @(negedge clk)
   begin
      if (cycle >= 1)
      begin
         if ((pending.size() > 0) && (pending[0].due == cycle))
         begin
            head = pending.pop_front();
            check_uop(head);
         end
         else
         begin
            assert (uop_valid === 1'b0)
            else
            begin
               $display("uop_valid high at cycle %0d with no result due", cycle);
               errors++;
            end
         end
      end
   end

   initial
   begin : stimulus
      int i;
      int gap;
      logic [riscv_decode_pkg::xlen-1:0] rpc;
      pend_t p;
      void'($urandom(seed));
      reset = 1'b1;
      insn_valid = 1'b0;
      insn = 32'd0;
      pc = '0;
      page_fault = 1'b0;
      irq = 1'b0;
      load_vectors();
      limit = vectors.size() * 4 + 50;
      repeat (3) @(posedge clk);
      #1 reset = 1'b0;
      for (i = 0; i < vectors.size(); i++)
      begin
         gap = $urandom % 3;                             // 0 keeps rows back to back
         insn_valid = 1'b0;
         repeat (gap)
         begin
            @(posedge clk);
            #1;
         end
         rpc = {$urandom, $urandom};
         rpc[1:0] = 2'b00;
         insn_valid = 1'b1;
         insn = vectors[i].stim[31:0];
         page_fault = vectors[i].stim[33];
         irq = vectors[i].stim[32];
         pc = rpc;
         p.idx = i;
         p.due = cycle + 2;                              // captured next edge, out one later
         p.pc = rpc;
         pending.push_back(p);
         @(posedge clk);
         #1;
      end
      insn_valid = 1'b0;
      while (pending.size() > 0)
         @(posedge clk);
      repeat (2) @(posedge clk);
      $display("%0d tests, %0d passed, %0d failed, %0d errors", vectors.size(), passed,
               failed, errors);
      if (errors == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

   initial
   begin : watchdog
      wait (limit > 0);
      while (cycle < limit)
         @(posedge clk);
      $display("run timed out at cycle %0d before all results came back", cycle);
      $display("TEST FAIL");
      $finish;
   end

endmodule
